// File: files.f
hw/gb_map_pkg.sv
hw/gb_bus_pkg.sv
hw/addr_decode.sv
hw/bus_arbiter.sv
hw/oam_dma.sv
hw/video_mem.sv
hw/reset_seq.sv
hw/gb_bus_top.sv
tb/gb_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= gb_bus_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/gb_bus_tb.sv
`timescale 1ns/1ps

module gb_bus_tb import gb_map_pkg::*, gb_bus_pkg::*; ();

	localparam int HALF_PERIOD = 10;
	localparam int RST_CYCLES = 8;
	localparam int RESET_LEN = 48; // Three phases of 16.
	localparam int OAM_LEN = 160;
	localparam int DMA_LEN = 2 * OAM_LEN; // Read cycle plus write cycle per byte.
	localparam int TEST_CYCLES = 1500; // Rough sum of all test lengths.
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
	localparam logic [31:0] SEED = 32'h820a_cd7e;
	localparam data_t IO_DATA = 8'h3C;

	logic        gbclk, n_crst_in, gb_on, cart_rst_n;
	logic        cpu_reset, cart_rst_drive, reset_done, dma_active;
	cpu_adr_t    cpu_adr;
	data_t       cpu_wdata, cpu_rdata;
	logic        cpu_rd, cpu_wr;
	logic        ppu_need_vram, ppu_need_oam, ppu_rd;
	cpu_adr_t    ppu_adr;
	data_t       ppu_vram_data;
	logic [15:0] ppu_oam_data16;
	cpu_adr_t    ext_adr;
	logic        ext_rd, ext_wr;
	data_t       ext_wdata, ext_rdata;
	region_t     ext_region;
	io_sel_t     io_sel;
	data_t       io_rdata;

	data_t ext_mem [65536];
	int    errors = 0;
	int    checks = 0;
	int    cycle_cnt = 0;

	gb_bus_top UUT (.*);

	always #HALF_PERIOD gbclk = !gbclk;

	// External memory answers one cycle after the strobe.
	always @(posedge gbclk) begin
		if (ext_rd)
			ext_rdata <= ext_mem[ext_adr.full];
		if (ext_wr)
			ext_mem[ext_adr.full] <= ext_wdata;
	end

	always @(posedge gbclk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
			$display("Checks run: %0d, errors: %0d", checks, errors);
			$display("Errors found");
			$finish;
		end
	end

	task automatic check_byte(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_region(input string name, input region_t got, input region_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_io(input string name, input io_sel_t got, input io_sel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_cycles(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("%s lasted %0d cycles instead of %0d", what, got, exp);
		end
	endtask

	task automatic cpu_write(input logic [15:0] adr, input data_t data);
		@(negedge gbclk);
		cpu_adr.full = adr;
		cpu_wdata = data;
		cpu_wr = 1'b1;
		@(negedge gbclk);
		cpu_wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] adr, output data_t data);
		@(negedge gbclk);
		cpu_adr.full = adr;
		cpu_rd = 1'b1;
		@(negedge gbclk);
		cpu_rd = 1'b0;
		data = cpu_rdata;
	endtask

	task automatic test_reset();
		int n;
		n = 0;
		check_bit("cpu_reset", cpu_reset, 1'b1);
		check_bit("dma_active", dma_active, 1'b0);
		check_bit("ext_rd", ext_rd, 1'b0);
		check_bit("ext_wr", ext_wr, 1'b0);
		check_bit("cart_rst_drive", cart_rst_drive, 1'b0);
		n_crst_in = 1'b1;
		while (cpu_reset && n < 2 * RESET_LEN) begin
			@(negedge gbclk);
			n++;
		end
		check_cycles("Power-on reset", n, RESET_LEN);
		check_bit("cart_rst_drive", cart_rst_drive, 1'b1);
		check_bit("reset_done", reset_done, 1'b1);
		cart_rst_n = 1'b0; // Cartridge pulls reset.
		@(negedge gbclk);
		check_bit("cpu_reset", cpu_reset, 1'b1);
		check_bit("cart_rst_drive", cart_rst_drive, 1'b0);
		cart_rst_n = 1'b1;
		n = 0;
		while (cpu_reset && n < 2 * RESET_LEN) begin
			@(negedge gbclk);
			n++;
		end
		checks++;
		if (cpu_reset) begin
			errors++;
			$display("cpu_reset stayed high after the cartridge released reset");
		end
	endtask

	task automatic decode_one(input logic [15:0] adr, input region_t exp_reg,
		input io_sel_t exp_io);
		logic    is_ext;
		region_t exp_ext;
		is_ext = exp_reg == REG_ROM || exp_reg == REG_XRAM || exp_reg == REG_WRAM;
		exp_ext = is_ext ? exp_reg : REG_NONE;
		@(negedge gbclk);
		cpu_adr.full = adr;
		cpu_rd = 1'b1;
		#(HALF_PERIOD / 2);
		check_region("ext_region", ext_region, exp_ext);
		check_bit("ext_rd", ext_rd, is_ext);
		check_io("io_sel", io_sel, exp_io);
		check_bit("ext_wr", ext_wr, 1'b0);
		if (is_ext) begin
			check_byte("ext_adr.page", ext_adr.paged.page, adr[15:8]);
			check_byte("ext_adr.offset", ext_adr.paged.offset, adr[7:0]);
		end
		@(negedge gbclk);
		cpu_rd = 1'b0;
		if (is_ext)
			check_byte("cpu_rdata", cpu_rdata, ext_mem[adr]);
		else if (exp_reg == REG_IO)
			check_byte("cpu_rdata", cpu_rdata, IO_DATA);
		else if (exp_reg == REG_NONE)
			check_byte("cpu_rdata", cpu_rdata, DATA_IDLE);
	endtask

	task automatic test_decode();
		decode_one(16'h0000, REG_ROM, IO_NONE);
		decode_one(16'h7FFF, REG_ROM, IO_NONE);
		decode_one(16'h8000, REG_VRAM, IO_NONE);
		decode_one(16'h9FFF, REG_VRAM, IO_NONE);
		decode_one(16'hA000, REG_XRAM, IO_NONE);
		decode_one(16'hBFFF, REG_XRAM, IO_NONE);
		decode_one(16'hC000, REG_WRAM, IO_NONE);
		decode_one(16'hE123, REG_WRAM, IO_NONE); // Echo area.
		decode_one(16'hFDFF, REG_WRAM, IO_NONE);
		decode_one(16'hFE00, REG_OAM, IO_NONE);
		decode_one(16'hFE9F, REG_OAM, IO_NONE);
		decode_one(16'hFEA0, REG_NONE, IO_NONE);
		decode_one(16'hFF00, REG_IO, IO_JOY);
		decode_one(16'hFF02, REG_IO, IO_SER);
		decode_one(16'hFF03, REG_IO, IO_NONE);
		decode_one(16'hFF05, REG_IO, IO_TIM);
		decode_one(16'hFF0F, REG_IO, IO_IFLAG);
		decode_one(16'hFF20, REG_IO, IO_SND);
		decode_one(16'hFF44, REG_IO, IO_PPU);
		decode_one(16'hFF50, REG_IO, IO_NONE);
		decode_one(16'hFF80, REG_IO, IO_HRAM);
		decode_one(16'hFFFE, REG_IO, IO_HRAM);
		decode_one(16'hFFFF, REG_IO, IO_IENA);
	endtask

	task automatic test_ext_write();
		data_t val, got;
		val = ~ext_mem[16'hA5C3];
		@(negedge gbclk);
		cpu_adr.full = 16'hA5C3;
		cpu_wdata = val;
		cpu_wr = 1'b1;
		#(HALF_PERIOD / 2);
		check_bit("ext_wr", ext_wr, 1'b1);
		check_bit("ext_rd", ext_rd, 1'b0);
		check_region("ext_region", ext_region, REG_XRAM);
		check_byte("ext_adr.page", ext_adr.paged.page, 8'hA5);
		check_byte("ext_adr.offset", ext_adr.paged.offset, 8'hC3);
		check_byte("ext_wdata", ext_wdata, val);
		@(negedge gbclk);
		cpu_wr = 1'b0;
		cpu_read(16'hA5C3, got);
		check_byte("cpu_rdata", got, val);
	endtask

	task automatic test_mem();
		logic [15:0] adrs [6];
		data_t       vals [6];
		data_t       got;
		adrs = '{16'h8000, 16'h8ABC, 16'h9FFF, 16'hFE00, 16'hFE51, 16'hFE9F};
		for (int i = 0; i < 6; i++) begin
			vals[i] = data_t'($urandom);
			cpu_write(adrs[i], vals[i]);
		end
		for (int i = 0; i < 6; i++) begin
			cpu_read(adrs[i], got);
			check_byte("cpu_rdata", got, vals[i]);
		end
	endtask

	task automatic test_priority();
		data_t old_val, got;
		old_val = data_t'($urandom);
		cpu_write(16'h8123, old_val);
		@(negedge gbclk);
		ppu_need_vram = 1'b1;
		cpu_read(16'h8123, got);
		check_byte("cpu_rdata", got, DATA_IDLE);
		cpu_write(16'h8123, ~old_val); // Must be dropped.
		@(negedge gbclk);
		ppu_adr.full = 16'h8123;
		ppu_rd = 1'b1;
		@(negedge gbclk);
		ppu_rd = 1'b0;
		check_byte("ppu_vram_data", ppu_vram_data, old_val);
		ppu_need_vram = 1'b0;
		cpu_read(16'h8123, got);
		check_byte("cpu_rdata", got, old_val);
	endtask

	task automatic test_dma();
		int          cycles;
		logic        pend;
		logic [15:0] src;
		data_t       got;
		cycles = 0;
		pend = 1'b0;
		cpu_write(16'hFF46, 8'hC1);
		while (dma_active && cycles < 2 * DMA_LEN) begin
			cycles++;
			if (pend) begin
				cpu_rd = 1'b0;
				pend = 1'b0;
				check_byte("cpu_rdata", cpu_rdata, DATA_IDLE);
			end else if (cycles % 64 == 0 && cycles < DMA_LEN - 10) begin
				cpu_adr.full = 16'hFE00 + 16'(cycles / 4);
				cpu_rd = 1'b1;
				pend = 1'b1;
			end
			@(negedge gbclk);
		end
		check_cycles("dma_active", cycles, DMA_LEN);
		for (int i = 0; i < OAM_LEN; i++) begin
			src = 16'hC100 + 16'(i);
			cpu_read(16'hFE00 + 16'(i), got);
			check_byte("cpu_rdata", got, ext_mem[src]);
		end
		ppu_need_oam = 1'b1;
		for (int i = 0; i < OAM_LEN; i += 2) begin
			src = 16'hC100 + 16'(i);
			@(negedge gbclk);
			ppu_adr.full = 16'hFE00 + 16'(i);
			ppu_rd = 1'b1;
			@(negedge gbclk);
			ppu_rd = 1'b0;
			check_byte("ppu_oam_data16[7:0]", ppu_oam_data16[7:0], ext_mem[src]);
			check_byte("ppu_oam_data16[15:8]", ppu_oam_data16[15:8], ext_mem[src + 16'd1]);
		end
		ppu_need_oam = 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		gbclk = 1'b0;
		n_crst_in = 1'b0;
		gb_on = 1'b1;
		cart_rst_n = 1'b1;
		cpu_adr = '0;
		cpu_wdata = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		ppu_need_vram = 1'b0;
		ppu_need_oam = 1'b0;
		ppu_adr = '0;
		ppu_rd = 1'b0;
		ext_rdata = '0;
		io_rdata = IO_DATA;
		for (int a = 0; a < 65536; a++)
			ext_mem[a[15:0]] = data_t'($urandom);
		repeat (RST_CYCLES) @(negedge gbclk);
		test_reset();
		test_decode();
		test_ext_write();
		test_mem();
		test_priority();
		test_dma();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: hw/gb_bus_top.sv
`timescale 1ns/1ps

module gb_bus_top import gb_map_pkg::*, gb_bus_pkg::*; (
	input  logic        gbclk,
	input  logic        n_crst_in,
	input  logic        gb_on,
	input  logic        cart_rst_n,
	output logic        cpu_reset,
	output logic        cart_rst_drive,
	output logic        reset_done,
	output logic        dma_active,
	input  cpu_adr_t    cpu_adr,
	input  data_t       cpu_wdata,
	input  logic        cpu_rd,
	input  logic        cpu_wr,
	output data_t       cpu_rdata,
	input  logic        ppu_need_vram,
	input  logic        ppu_need_oam,
	input  cpu_adr_t    ppu_adr,
	input  logic        ppu_rd,
	output data_t       ppu_vram_data,
	output logic [15:0] ppu_oam_data16,
	output cpu_adr_t    ext_adr,
	output logic        ext_rd,
	output logic        ext_wr,
	output data_t       ext_wdata,
	output region_t     ext_region,
	input  data_t       ext_rdata,
	output io_sel_t     io_sel,
	input  data_t       io_rdata
);

	region_t               cpu_region, dma_region;
	logic                  dma_reg_hit;
	cpu_adr_t              dma_src_adr;
	logic                  dma_rd, dma_wr;
	logic [OAM_ADR_W-1:0]  dma_oam_adr;
	data_t                 dma_wdata, dma_rdata;
	logic [VRAM_ADR_W-1:0] vram_adr;
	logic                  vram_rd, vram_wr;
	data_t                 vram_wdata;
	logic [OAM_ADR_W-1:0]  oam_adr;
	logic                  oam_rd, oam_wr;
	data_t                 oam_wdata, oam_rdata;

	assign ext_wdata = cpu_wdata;

	reset_seq u_reset_seq (
		.gbclk(gbclk), .n_crst_in(n_crst_in), .gb_on(gb_on), .cart_rst_n(cart_rst_n),
		.cpu_reset(cpu_reset), .cart_rst_drive(cart_rst_drive), .reset_done(reset_done)
	);

	addr_decode u_addr_decode (
		.cpu_adr(cpu_adr), .dma_src_adr(dma_src_adr), .cpu_region(cpu_region),
		.io_sel(io_sel), .dma_reg_hit(dma_reg_hit), .dma_region(dma_region)
	);

	bus_arbiter u_bus_arbiter (
		.gbclk(gbclk), .n_crst_in(n_crst_in), .cpu_region(cpu_region),
		.dma_region(dma_region), .dma_active(dma_active), .ppu_need_vram(ppu_need_vram),
		.ppu_need_oam(ppu_need_oam), .cpu_adr(cpu_adr), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
		.cpu_wdata(cpu_wdata), .dma_src_adr(dma_src_adr), .dma_rd(dma_rd),
		.dma_oam_adr(dma_oam_adr), .dma_wr(dma_wr), .dma_wdata(dma_wdata),
		.ppu_adr(ppu_adr), .ppu_rd(ppu_rd), .vram_rdata(ppu_vram_data),
		.oam_rdata(oam_rdata), .ext_rdata(ext_rdata), .io_rdata(io_rdata),
		.vram_adr(vram_adr), .vram_rd(vram_rd), .vram_wr(vram_wr), .vram_wdata(vram_wdata),
		.oam_adr(oam_adr), .oam_rd(oam_rd), .oam_wr(oam_wr), .oam_wdata(oam_wdata),
		.ext_adr(ext_adr), .ext_rd(ext_rd), .ext_wr(ext_wr), .ext_region(ext_region),
		.cpu_rdata(cpu_rdata), .dma_rdata(dma_rdata)
	);

	oam_dma u_oam_dma (
		.gbclk(gbclk), .n_crst_in(n_crst_in), .start(cpu_wr && dma_reg_hit),
		.start_page(cpu_wdata), .src_rdata(dma_rdata), .dma_active(dma_active),
		.dma_src_adr(dma_src_adr), .dma_rd(dma_rd), .dma_oam_adr(dma_oam_adr),
		.dma_wr(dma_wr), .dma_wdata(dma_wdata)
	);

	video_mem u_video_mem (
		.gbclk(gbclk), .vram_adr(vram_adr), .vram_rd(vram_rd), .vram_wr(vram_wr),
		.vram_wdata(vram_wdata), .oam_adr(oam_adr), .oam_rd(oam_rd), .oam_wr(oam_wr),
		.oam_wdata(oam_wdata), .vram_rdata(ppu_vram_data), .oam_rdata(oam_rdata),
		.oam_rdata16(ppu_oam_data16)
	);

endmodule

// File: hw/reset_seq.sv
`timescale 1ns/1ps

module reset_seq import gb_bus_pkg::*; (
	input  logic gbclk,
	input  logic n_crst_in,
	input  logic gb_on,
	input  logic cart_rst_n,
	output logic cpu_reset,
	output logic cart_rst_drive,
	output logic reset_done
);

	logic [1:0]            r_state;
	logic [RST_TICK_W-1:0] r_ticks;
	logic                  r_gb_on;
	logic                  last_tick;
	logic                  restart;

	assign last_tick = r_ticks == RST_TICK_W'(RST_TICKS - 1);
	// Power toggle or cartridge pulling reset once running.
	assign restart = r_state != RST_INIT &&
		(r_gb_on != gb_on || (r_state == RST_DONE && !cart_rst_n));

	always_ff @(posedge gbclk) begin
		if (!n_crst_in) begin
			r_state <= RST_INIT;
			r_ticks <= '0;
			r_gb_on <= 1'b0;
		end else begin
			r_gb_on <= gb_on;
			if (restart) begin
				r_state <= RST_ASSERT;
				r_ticks <= '0;
			end else begin
				case (r_state)
				RST_INIT, RST_ASSERT: begin
					r_ticks <= last_tick ? '0 : r_ticks + 1'b1;
					if (last_tick)
						r_state <= r_state == RST_INIT ? RST_ASSERT : RST_RELEASE;
				end
				RST_RELEASE: begin
					if (!cart_rst_n)
						r_ticks <= '0; // Cartridge still holds reset.
					else if (last_tick)
						r_state <= RST_DONE;
					else
						r_ticks <= r_ticks + 1'b1;
				end
				default: ;
				endcase
			end
		end
	end

	assign reset_done = r_state == RST_DONE;
	assign cpu_reset = !reset_done || !gb_on;
	assign cart_rst_drive = r_state == RST_RELEASE || r_state == RST_DONE;

endmodule

// File: hw/video_mem.sv
`timescale 1ns/1ps

module video_mem import gb_map_pkg::*, gb_bus_pkg::*; (
	input  logic                  gbclk,
	input  logic [VRAM_ADR_W-1:0] vram_adr,
	input  logic                  vram_rd,
	input  logic                  vram_wr,
	input  data_t                 vram_wdata,
	input  logic [OAM_ADR_W-1:0]  oam_adr,
	input  logic                  oam_rd,
	input  logic                  oam_wr,
	input  data_t                 oam_wdata,
	output data_t                 vram_rdata,
	output data_t                 oam_rdata,
	output logic [15:0]           oam_rdata16
);

	data_t vram [2**VRAM_ADR_W];
	data_t oam [OAM_BYTES];

	logic                 oam_hit;
	logic [OAM_ADR_W-1:0] even_adr, odd_adr;

	assign oam_hit = oam_adr < OAM_ADR_W'(OAM_BYTES); // FEA0 and up is unused.
	assign even_adr = {oam_adr[OAM_ADR_W-1:1], 1'b0};
	assign odd_adr = {oam_adr[OAM_ADR_W-1:1], 1'b1};

	always_ff @(posedge gbclk) begin
		if (vram_wr)
			vram[vram_adr] <= vram_wdata;
		if (vram_rd)
			vram_rdata <= vram[vram_adr];
	end

	always_ff @(posedge gbclk) begin
		if (oam_wr && oam_hit)
			oam[oam_adr] <= oam_wdata;
		if (oam_rd) begin
			if (oam_hit) begin
				oam_rdata <= oam[oam_adr];
				oam_rdata16 <= {oam[odd_adr], oam[even_adr]}; // Even byte low.
			end else begin
				oam_rdata <= DATA_IDLE;
				oam_rdata16 <= {DATA_IDLE, DATA_IDLE};
			end
		end
	end

endmodule

// File: hw/oam_dma.sv
`timescale 1ns/1ps

module oam_dma import gb_map_pkg::*, gb_bus_pkg::*; (
	input  logic                 gbclk,
	input  logic                 n_crst_in,
	input  logic                 start,
	input  data_t                start_page,
	input  data_t                src_rdata,
	output logic                 dma_active,
	output cpu_adr_t             dma_src_adr,
	output logic                 dma_rd,
	output logic [OAM_ADR_W-1:0] dma_oam_adr,
	output logic                 dma_wr,
	output data_t                dma_wdata
);

	logic                 r_active;
	logic                 r_phase; // High in the write cycle.
	logic [OAM_ADR_W-1:0] r_index;
	data_t                r_page;

	always_ff @(posedge gbclk) begin
		if (!n_crst_in) begin
			r_active <= 1'b0;
			r_phase <= 1'b0;
			r_index <= '0;
		end else if (start) begin
			r_active <= 1'b1; // A new write restarts the copy.
			r_phase <= 1'b0;
			r_index <= '0;
		end else if (r_active) begin
			r_phase <= !r_phase;
			if (r_phase) begin
				if (r_index == OAM_ADR_W'(OAM_BYTES - 1))
					r_active <= 1'b0;
				else
					r_index <= r_index + 1'b1;
			end
		end
	end

	always_ff @(posedge gbclk) begin
		if (start)
			r_page <= start_page;
	end

	always_comb begin
		dma_active = r_active;
		dma_src_adr.paged.page = r_page;
		dma_src_adr.paged.offset = r_index;
		dma_rd = r_active && !r_phase;
		dma_wr = r_active && r_phase;
		dma_oam_adr = r_index;
		dma_wdata = src_rdata; // Source data lands in the write cycle.
	end

	a_index_range: assert property (@(posedge gbclk) disable iff (!n_crst_in)
		r_active |-> r_index < OAM_ADR_W'(OAM_BYTES));

	a_busy_len: assert property (@(posedge gbclk) disable iff (!n_crst_in)
		start |=> dma_active [*DMA_CYCLES]);

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import gb_map_pkg::*, gb_bus_pkg::*; (
	input  logic                  gbclk,
	input  logic                  n_crst_in,
	input  region_t               cpu_region,
	input  region_t               dma_region,
	input  logic                  dma_active,
	input  logic                  ppu_need_vram,
	input  logic                  ppu_need_oam,
	input  cpu_adr_t              cpu_adr,
	input  logic                  cpu_rd,
	input  logic                  cpu_wr,
	input  data_t                 cpu_wdata,
	input  cpu_adr_t              dma_src_adr,
	input  logic                  dma_rd,
	input  logic [OAM_ADR_W-1:0]  dma_oam_adr,
	input  logic                  dma_wr,
	input  data_t                 dma_wdata,
	input  cpu_adr_t              ppu_adr,
	input  logic                  ppu_rd,
	input  data_t                 vram_rdata,
	input  data_t                 oam_rdata,
	input  data_t                 ext_rdata,
	input  data_t                 io_rdata,
	output logic [VRAM_ADR_W-1:0] vram_adr,
	output logic                  vram_rd,
	output logic                  vram_wr,
	output data_t                 vram_wdata,
	output logic [OAM_ADR_W-1:0]  oam_adr,
	output logic                  oam_rd,
	output logic                  oam_wr,
	output data_t                 oam_wdata,
	output cpu_adr_t              ext_adr,
	output logic                  ext_rd,
	output logic                  ext_wr,
	output region_t               ext_region,
	output data_t                 cpu_rdata,
	output data_t                 dma_rdata
);

	function automatic logic is_ext(region_t r);
		return r == REG_ROM || r == REG_XRAM || r == REG_WRAM;
	endfunction

	owner_t  vram_own, oam_own, cpu_own;
	logic    ext_dma, cpu_ext;
	region_t r_rd_region, r_dma_region;
	owner_t  r_rd_own;
	logic    r_dma_ok;

	always_comb begin
		ext_dma = dma_active && is_ext(dma_region);
		cpu_ext = is_ext(cpu_region);

		if (ppu_need_vram)
			vram_own = OWN_PPU;
		else if (dma_active && dma_region == REG_VRAM)
			vram_own = OWN_DMA;
		else
			vram_own = cpu_region == REG_VRAM ? OWN_CPU : OWN_NONE;

		if (ppu_need_oam)
			oam_own = OWN_PPU;
		else if (dma_active)
			oam_own = OWN_DMA;
		else
			oam_own = cpu_region == REG_OAM ? OWN_CPU : OWN_NONE;

		case (cpu_region)
		REG_VRAM: cpu_own = vram_own;
		REG_OAM:  cpu_own = oam_own;
		REG_IO:   cpu_own = OWN_CPU;
		REG_ROM, REG_XRAM, REG_WRAM: cpu_own = ext_dma ? OWN_DMA : OWN_CPU;
		default:  cpu_own = OWN_NONE;
		endcase
	end

	always_comb begin
		vram_adr = cpu_adr.full[VRAM_ADR_W-1:0];
		vram_rd = 1'b0;
		vram_wr = 1'b0;
		vram_wdata = cpu_wdata; // Only the CPU writes video RAM.
		case (vram_own)
		OWN_PPU: begin
			vram_adr = ppu_adr.full[VRAM_ADR_W-1:0];
			vram_rd = ppu_rd;
		end
		OWN_DMA: begin
			vram_adr = dma_src_adr.full[VRAM_ADR_W-1:0];
			vram_rd = dma_rd;
		end
		OWN_CPU: begin
			vram_rd = cpu_rd;
			vram_wr = cpu_wr;
		end
		default: ;
		endcase
	end

	always_comb begin
		oam_adr = cpu_adr.paged.offset;
		oam_rd = 1'b0;
		oam_wr = 1'b0;
		oam_wdata = cpu_wdata;
		case (oam_own)
		OWN_PPU: begin
			oam_adr = ppu_adr.paged.offset;
			oam_rd = ppu_rd;
		end
		OWN_DMA: begin
			oam_adr = dma_oam_adr;
			oam_wr = dma_wr;
			oam_wdata = dma_wdata;
		end
		OWN_CPU: begin
			oam_rd = cpu_rd;
			oam_wr = cpu_wr;
		end
		default: ;
		endcase
	end

	always_comb begin
		if (ext_dma) begin
			ext_adr = dma_src_adr;
			ext_rd = dma_rd;
			ext_wr = 1'b0;
			ext_region = dma_region;
		end else begin
			ext_adr = cpu_adr;
			ext_rd = cpu_rd && cpu_ext;
			ext_wr = cpu_wr && cpu_ext;
			ext_region = cpu_ext ? cpu_region : REG_NONE;
		end
	end

	// Remember where each read went; the data returns a cycle later.
	always_ff @(posedge gbclk) begin
		if (!n_crst_in) begin
			r_rd_region <= REG_NONE;
			r_rd_own <= OWN_NONE;
			r_dma_region <= REG_NONE;
			r_dma_ok <= 1'b0;
		end else begin
			r_rd_region <= cpu_rd ? cpu_region : REG_NONE;
			r_rd_own <= cpu_rd ? cpu_own : OWN_NONE;
			r_dma_region <= dma_region;
			r_dma_ok <= dma_rd && (ext_dma || vram_own == OWN_DMA);
		end
	end

	always_comb begin
		cpu_rdata = DATA_IDLE;
		if (r_rd_own == OWN_CPU) begin
			case (r_rd_region)
			REG_VRAM: cpu_rdata = vram_rdata;
			REG_OAM:  cpu_rdata = oam_rdata;
			REG_IO:   cpu_rdata = io_rdata;
			REG_ROM, REG_XRAM, REG_WRAM: cpu_rdata = ext_rdata;
			default:  cpu_rdata = DATA_IDLE;
			endcase
		end
		if (!r_dma_ok)
			dma_rdata = DATA_IDLE;
		else
			dma_rdata = r_dma_region == REG_VRAM ? vram_rdata : ext_rdata;
	end

	a_no_vram_wr_ppu: assert property (@(posedge gbclk) disable iff (!n_crst_in)
		ppu_need_vram |-> !vram_wr);

endmodule

// File: hw/addr_decode.sv
`timescale 1ns/1ps

module addr_decode import gb_map_pkg::*; (
	input  cpu_adr_t cpu_adr,
	input  cpu_adr_t dma_src_adr,
	output region_t  cpu_region,
	output io_sel_t  io_sel,
	output logic     dma_reg_hit,
	output region_t  dma_region
);

	function automatic region_t decode_region(cpu_adr_t a);
		if (!a.full[15])
			return REG_ROM;
		if (a.full[15:13] == 3'b100)
			return REG_VRAM;
		if (a.full[15:13] == 3'b101)
			return REG_XRAM;
		if (a.full < 16'hFE00)
			return REG_WRAM; // Includes the echo area.
		if (a.full < 16'hFEA0)
			return REG_OAM;
		if (a.paged.page == IO_PAGE)
			return REG_IO;
		return REG_NONE;
	endfunction

	function automatic io_sel_t decode_io(logic [ADR_W/2-1:0] ofs);
		if (ofs == 8'h00)
			return IO_JOY;
		if (ofs == 8'h01 || ofs == 8'h02)
			return IO_SER;
		if (ofs >= 8'h04 && ofs <= 8'h07)
			return IO_TIM;
		if (ofs == 8'h0F)
			return IO_IFLAG;
		if (ofs >= 8'h10 && ofs <= 8'h3F)
			return IO_SND;
		if (ofs >= 8'h40 && ofs <= 8'h4B)
			return IO_PPU; // DMA register sits here too.
		if (ofs == 8'hFF)
			return IO_IENA;
		if (ofs >= 8'h80)
			return IO_HRAM;
		return IO_NONE;
	endfunction

	logic io_page;

	assign io_page = cpu_adr.paged.page == IO_PAGE;

	always_comb begin
		cpu_region = decode_region(cpu_adr);
		dma_region = decode_region(dma_src_adr);
		io_sel = io_page ? decode_io(cpu_adr.paged.offset) : IO_NONE;
		dma_reg_hit = io_page && cpu_adr.paged.offset == DMA_REG_OFS;
	end

endmodule

// File: hw/gb_bus_pkg.sv
package gb_bus_pkg;

	localparam int DATA_W = 8;
	localparam int OAM_ADR_W = 8;

	typedef logic [DATA_W-1:0] data_t;

	localparam data_t DATA_IDLE = 8'hFF; // Value of an undriven bus.

	typedef enum logic [1:0] {
		OWN_NONE, OWN_PPU, OWN_DMA, OWN_CPU
	} owner_t;

	// Two cycles per byte.
	localparam int DMA_CYCLES = 320;

	localparam int RST_TICKS = 16;
	localparam int RST_TICK_W = $clog2(RST_TICKS);

	// Reset sequencer phases.
	localparam logic [1:0] RST_INIT = 2'd0;
	localparam logic [1:0] RST_ASSERT = 2'd1;
	localparam logic [1:0] RST_RELEASE = 2'd2;
	localparam logic [1:0] RST_DONE = 2'd3;

endpackage

// File: hw/gb_map_pkg.sv
package gb_map_pkg;

	localparam int ADR_W = 16;
	localparam int VRAM_ADR_W = 13;
	localparam int OAM_BYTES = 160;
	localparam logic [7:0] IO_PAGE = 8'hFF;
	localparam logic [7:0] DMA_REG_OFS = 8'h46;

	typedef struct packed {
		logic [ADR_W/2-1:0] page;
		logic [ADR_W/2-1:0] offset;
	} adr_paged_t;

	// One address word, seen either whole or as page and offset.
	typedef union packed {
		logic [ADR_W-1:0] full;
		adr_paged_t       paged;
	} cpu_adr_t;

	typedef enum logic [2:0] {
		REG_NONE, REG_ROM, REG_VRAM, REG_XRAM, REG_WRAM, REG_OAM, REG_IO
	} region_t;

	typedef enum logic [3:0] {
		IO_NONE,
		IO_JOY,
		IO_SER,
		IO_TIM,
		IO_IFLAG,
		IO_SND,
		IO_PPU,
		IO_HRAM,
		IO_IENA
	} io_sel_t;

endpackage
